/* Makefile */
VERILATOR ?= verilator
TOP ?= pq_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build $(TOP) with Verilator, run it and search the output for the pass message"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)

/* project.f */
source/pq_pkg.sv
source/pq_fifo.sv
source/pq_cmd_decode.sv
source/pq_extreme_scan.sv
source/pq_store.sv
source/pq_top.sv
verification/pq_sva.sv
verification/pq_tb.sv

/* source/pq_cmd_decode.sv */
`timescale 1ns/1ps

module pq_cmd_decode (
  input  logic                      clk_in,
  input  logic                      rst_in,
  input  logic                      cmd_valid,
  input  pq_pkg::op_e               cmd_op,
  input  logic [pq_pkg::TAG_W-1:0]  cmd_tag,
  input  logic [pq_pkg::DATA_W-1:0] cmd_data,
  input  logic                      exec_idle,
  output logic                      cmd_drop,
  output logic                      issue_valid,
  output pq_pkg::op_e               issue_op,
  output logic [pq_pkg::TAG_W-1:0]  issue_tag,
  output logic [pq_pkg::DATA_W-1:0] issue_data,
  output logic                      busy
);
  import pq_pkg::*;

  cmd_t cmd_in;
  cmd_t cmd_head;
  logic fifo_empty;
  logic fifo_full;
  logic pop;
  logic in_flight;

  assign cmd_in = '{op: cmd_op, tag: cmd_tag, data: cmd_data};

  pq_fifo #(
    .item_t (cmd_t),
    .DEPTH_P(CMD_FIFO_DEPTH),
    .PRELOAD(1'b0)
  ) cmd_fifo_inst (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .push     (cmd_valid),
    .push_item(cmd_in),
    .pop      (pop),
    .head     (cmd_head),
    .empty    (fifo_empty),
    .full     (fifo_full)
  );

  // fifo ignores the push when full, so the command is lost here
  assign cmd_drop = cmd_valid && fifo_full;
  assign pop = exec_idle && !in_flight && !fifo_empty;
  assign busy = !fifo_empty || in_flight || !exec_idle;

  // in_flight covers the cycle before execute has seen the issue strobe
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      issue_valid <= 1'b0;
      in_flight <= 1'b0;
    end else begin
      issue_valid <= pop;
      if (pop) begin
        in_flight <= 1'b1;
      end else if (exec_idle && !issue_valid) begin
        in_flight <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (pop) begin
      issue_op <= cmd_head.op;
      issue_tag <= cmd_head.tag;
      issue_data <= cmd_head.data;
    end
  end

endmodule

/* source/pq_extreme_scan.sv */
`timescale 1ns/1ps

module pq_extreme_scan (
  input  logic                                       clk_in,
  input  logic                                       rst_in,
  input  logic                                       scan_start,
  input  logic                                       scan_want_max,
  input  logic [pq_pkg::DEPTH-1:0]                   slot_valid,
  input  logic [pq_pkg::DEPTH-1:0][pq_pkg::TAG_W-1:0] slot_tags,
  output logic                                       scan_done,
  output logic                                       scan_hit,
  output pq_pkg::slot_t                              scan_slot
);
  import pq_pkg::*;

  logic active;
  logic last;
  logic want_max;
  logic found;
  slot_t idx;
  slot_t best_slot;
  logic [TAG_W-1:0] best_tag;
  logic [TAG_W-1:0] cur_tag;
  logic better;
  logic take;

  // one comparator, one slot per clock
  assign cur_tag = slot_tags[idx];
  assign better = want_max ? (cur_tag > best_tag) : (cur_tag < best_tag);
  // strict compare keeps the first slot on equal tags
  assign take = active && slot_valid[idx] && (!found || better);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      active <= 1'b0;
      last <= 1'b0;
      found <= 1'b0;
      want_max <= 1'b0;
      idx <= '0;
      scan_done <= 1'b0;
    end else begin
      scan_done <= last;
      last <= 1'b0;
      if (scan_start) begin
        active <= 1'b1;
        idx <= '0;
        found <= 1'b0;
        want_max <= scan_want_max;
      end else if (active) begin
        if (take) begin
          found <= 1'b1;
        end
        if (idx == SLOT_W'(DEPTH - 1)) begin
          active <= 1'b0;
          last <= 1'b1;
        end else begin
          idx <= idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (scan_start) begin
      best_tag <= '0;
    end else if (take) begin
      best_tag <= cur_tag;
      best_slot <= idx;
    end
    // answer registered one cycle after the last slot
    if (last) begin
      scan_hit <= found;
      scan_slot <= best_slot;
    end
  end

endmodule

/* source/pq_fifo.sv */
`timescale 1ns/1ps

module pq_fifo #(
  parameter type item_t = logic [7:0],
  parameter int DEPTH_P = 4,
  parameter bit PRELOAD = 1'b0
) (
  input  logic  clk_in,
  input  logic  rst_in,
  input  logic  push,
  input  item_t push_item,
  input  logic  pop,
  output item_t head,
  output logic  empty,
  output logic  full
);

  localparam int PTR_W = (DEPTH_P > 1) ? $clog2(DEPTH_P) : 1;
  localparam int CNT_W = $clog2(DEPTH_P + 1);
  localparam int ITEM_W = $bits(item_t);

  item_t mem [DEPTH_P];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] level;
  logic do_push;
  logic do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH_P - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty = (level == '0);
  assign full = (level == CNT_W'(DEPTH_P));
  // head is visible without a pop
  assign head = mem[rd_ptr];
  assign do_push = push && !full;
  assign do_pop = pop && !empty;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      level <= PRELOAD ? CNT_W'(DEPTH_P) : '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (do_push && !do_pop) begin
        level <= level + 1'b1;
      end else if (do_pop && !do_push) begin
        level <= level - 1'b1;
      end
    end
  end

  // preload entry i with value i, so the buffer starts full of slot indices
  always_ff @(posedge clk_in) begin
    if (rst_in && PRELOAD) begin
      for (int i = 0; i < DEPTH_P; i++) begin
        mem[i] <= item_t'(ITEM_W'(i));
      end
    end else if (!rst_in && do_push) begin
      mem[wr_ptr] <= push_item;
    end
  end

endmodule

/* source/pq_pkg.sv */
package pq_pkg;

  // storage geometry
  localparam int DEPTH = 8;
  localparam int SLOT_W = 3;
  localparam int COUNT_W = 4;

  // entry payload
  localparam int TAG_W = 16;
  localparam int DATA_W = 16;

  localparam int CMD_FIFO_DEPTH = 4;

  typedef enum logic [1:0] {
    OP_ENQ     = 2'd0,
    OP_DEQ_MIN = 2'd1,
    OP_DEQ_MAX = 2'd2
  } op_e;

  // one queued client command
  typedef struct packed {
    op_e               op;
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] data;
  } cmd_t;

  typedef logic [SLOT_W-1:0] slot_t;

endpackage

/* source/pq_store.sv */
`timescale 1ns/1ps

module pq_store (
  input  logic                                       clk_in,
  input  logic                                       rst_in,
  input  logic                                       issue_valid,
  input  pq_pkg::op_e                                issue_op,
  input  logic [pq_pkg::TAG_W-1:0]                   issue_tag,
  input  logic [pq_pkg::DATA_W-1:0]                  issue_data,
  input  pq_pkg::slot_t                              free_head,
  input  logic                                       free_empty,
  input  logic                                       scan_done,
  input  logic                                       scan_hit,
  input  pq_pkg::slot_t                              scan_slot,
  output logic                                       exec_idle,
  output logic                                       alloc,
  output logic                                       release_en,
  output pq_pkg::slot_t                              release_slot,
  output logic                                       scan_start,
  output logic                                       scan_want_max,
  output logic [pq_pkg::DEPTH-1:0]                   slot_valid,
  output logic [pq_pkg::DEPTH-1:0][pq_pkg::TAG_W-1:0] slot_tags,
  output logic                                       res_valid,
  output logic [pq_pkg::TAG_W-1:0]                   res_tag,
  output logic [pq_pkg::DATA_W-1:0]                  res_data,
  output logic                                       res_empty,
  output logic                                       enq_rejected,
  output logic [pq_pkg::COUNT_W-1:0]                 count
);
  import pq_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_SCAN
  } state_e;

  state_e state;
  logic [DATA_W-1:0] data_mem [DEPTH];
  logic enq_cmd;
  logic deq_cmd;
  logic finish;

  assign exec_idle = (state == ST_IDLE);
  assign enq_cmd = exec_idle && issue_valid && (issue_op == OP_ENQ);
  assign deq_cmd = exec_idle && issue_valid && (issue_op != OP_ENQ);

  // free fifo head is the slot written this cycle
  assign alloc = enq_cmd && !free_empty;
  assign finish = (state == ST_SCAN) && scan_done;
  assign release_en = finish && scan_hit;
  assign release_slot = scan_slot;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= ST_IDLE;
      slot_valid <= '0;
      count <= '0;
      scan_start <= 1'b0;
      scan_want_max <= 1'b0;
      res_valid <= 1'b0;
      enq_rejected <= 1'b0;
    end else begin
      scan_start <= deq_cmd;
      res_valid <= finish;
      enq_rejected <= enq_cmd && free_empty;
      if (alloc) begin
        slot_valid[free_head] <= 1'b1;
        count <= count + 1'b1;
      end
      if (deq_cmd) begin
        state <= ST_SCAN;
        scan_want_max <= (issue_op == OP_DEQ_MAX);
      end
      // winner leaves the store and its slot goes back to the free fifo
      if (finish) begin
        state <= ST_IDLE;
        if (scan_hit) begin
          slot_valid[scan_slot] <= 1'b0;
          count <= count - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (alloc) begin
      slot_tags[free_head] <= issue_tag;
      data_mem[free_head] <= issue_data;
    end
    if (finish) begin
      res_empty <= !scan_hit;
      res_tag <= scan_hit ? slot_tags[scan_slot] : '0;
      res_data <= scan_hit ? data_mem[scan_slot] : '0;
    end
  end

endmodule

/* source/pq_top.sv */
`timescale 1ns/1ps

module pq_top (
  input  logic                      clk_in,
  input  logic                      rst_in,
  input  logic                      cmd_valid,
  input  pq_pkg::op_e               cmd_op,
  input  logic [pq_pkg::TAG_W-1:0]  cmd_tag,
  input  logic [pq_pkg::DATA_W-1:0] cmd_data,
  output logic                      cmd_drop,
  output logic                      res_valid,
  output logic [pq_pkg::TAG_W-1:0]  res_tag,
  output logic [pq_pkg::DATA_W-1:0] res_data,
  output logic                      res_empty,
  output logic                      enq_rejected,
  output logic [pq_pkg::COUNT_W-1:0] count,
  output logic                      busy
);
  import pq_pkg::*;

  // decode to execute
  logic exec_idle;
  logic issue_valid;
  op_e issue_op;
  logic [TAG_W-1:0] issue_tag;
  logic [DATA_W-1:0] issue_data;

  // store to free-slot fifo
  slot_t free_head;
  logic free_empty;
  logic alloc;
  logic release_en;
  slot_t release_slot;

  // store to scan
  logic scan_start;
  logic scan_want_max;
  logic [DEPTH-1:0] slot_valid;
  logic [DEPTH-1:0][TAG_W-1:0] slot_tags;
  logic scan_done;
  logic scan_hit;
  slot_t scan_slot;

  pq_cmd_decode pq_cmd_decode_inst (.*);

  pq_store pq_store_inst (.*);

  pq_extreme_scan pq_extreme_scan_inst (.*);

  // starts full with slots 0..DEPTH-1 and never holds a slot twice
  pq_fifo #(
    .item_t (slot_t),
    .DEPTH_P(DEPTH),
    .PRELOAD(1'b1)
  ) free_fifo_inst (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .push     (release_en),
    .push_item(release_slot),
    .pop      (alloc),
    .head     (free_head),
    .empty    (free_empty),
    .full     ()
  );

endmodule

/* verification/pq_sva.sv */
`timescale 1ns/1ps

module pq_sva (
  input logic                       clk_in,
  input logic                       rst_in,
  input logic                       cmd_valid,
  input logic                       cmd_drop,
  input logic                       issue_valid,
  input logic                       res_valid,
  input logic [pq_pkg::COUNT_W-1:0] count
);
  import pq_pkg::*;

  // tally of failed assertions
  int fail_count = 0;
  // commands accepted and not yet taken by execute
  int pending;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pending <= 0;
    end else begin
      pending <= pending + int'(cmd_valid && !cmd_drop) - int'(issue_valid);
    end
  end

  // a result is a single-cycle strobe
  res_single: assert property (@(posedge clk_in) disable iff (rst_in)
    res_valid |=> !res_valid)
    else begin
      $error("res_valid high on two consecutive cycles");
      fail_count++;
    end

  count_limit: assert property (@(posedge clk_in) disable iff (rst_in)
    count <= COUNT_W'(DEPTH))
    else begin
      $error("count above the number of slots");
      fail_count++;
    end

  // a drop belongs to a strobed command that meets a full command fifo
  drop_needs_cmd: assert property (@(posedge clk_in) disable iff (rst_in)
    cmd_drop |-> cmd_valid && (pending == CMD_FIFO_DEPTH + int'(issue_valid)))
    else begin
      $error("cmd_drop without cmd_valid or with room in the command fifo");
      fail_count++;
    end

endmodule

bind pq_top pq_sva pq_sva_inst (.*);

/* verification/pq_tb.sv */
`timescale 1ns/1ps

module pq_tb;
  import pq_pkg::*;

  localparam int CLK_HALF = 20;
  localparam int MAX_LINES = 64;

  logic clk_in;
  logic rst_in;
  logic cmd_valid;
  op_e cmd_op;
  logic [TAG_W-1:0] cmd_tag;
  logic [DATA_W-1:0] cmd_data;
  logic cmd_drop;
  logic res_valid;
  logic [TAG_W-1:0] res_tag;
  logic [DATA_W-1:0] res_data;
  logic res_empty;
  logic enq_rejected;
  logic [COUNT_W-1:0] count;
  logic busy;

  // columns of the data file with one row per command
  int n_cmds = 0;
  int t_num [MAX_LINES];
  int t_op [MAX_LINES];
  int t_tag [MAX_LINES];
  int t_data [MAX_LINES];
  int t_exp_tag [MAX_LINES];
  int t_exp_data [MAX_LINES];
  int t_flag [MAX_LINES];
  int t_count [MAX_LINES];
  int t_gap [MAX_LINES];

  // reference queue contents
  int m_tag [$];
  int m_data [$];

  // outstanding strobes in command order where kind 1 is an enqueue rejection
  int e_kind [$];
  int e_tag [$];
  int e_data [$];
  int e_empty [$];
  int e_count [$];

  int errors = 0;
  int checks = 0;

  pq_top pq_top_inst (.*);

  initial clk_in = 1'b0;
  always #(CLK_HALF) clk_in = ~clk_in;

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("error at %0d ns: %s got %h expected %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic load_testdata();
    int fd;
    int n;
    string line;
    fd = $fopen("verification/pq_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open verification/pq_testdata.txt");
      errors++;
      return;
    end
    while (!$feof(fd) && n_cmds < MAX_LINES) begin
      line = "";
      n = $fgets(line, fd);
      // skip comment and blank lines
      if (n > 1 && line[0] != "#") begin
        n = $sscanf(line, "%d %d %h %h %h %h %d %d %d", t_num[n_cmds], t_op[n_cmds],
                    t_tag[n_cmds], t_data[n_cmds], t_exp_tag[n_cmds], t_exp_data[n_cmds],
                    t_flag[n_cmds], t_count[n_cmds], t_gap[n_cmds]);
        if (n == 9) begin
          n_cmds++;
        end
      end
    end
    $fclose(fd);
  endtask

  // predicts the outcome of command i and queues the strobe it should cause
  task automatic apply_model(input int i);
    int best;
    int p_tag;
    int p_data;
    int p_flag;
    p_tag = 0;
    p_data = 0;
    p_flag = 0;
    if (t_flag[i] == 2) begin
      p_flag = 2;
    end else if (t_op[i] == 0) begin
      if (m_tag.size() == DEPTH) begin
        p_flag = 1;
        e_kind.push_back(1);
        e_tag.push_back(0);
        e_data.push_back(0);
        e_empty.push_back(0);
        e_count.push_back(DEPTH);
      end else begin
        m_tag.push_back(t_tag[i]);
        m_data.push_back(t_data[i]);
      end
    end else begin
      if (m_tag.size() == 0) begin
        p_flag = 1;
      end else begin
        best = 0;
        for (int k = 1; k < m_tag.size(); k++) begin
          if ((t_op[i] == 1 && m_tag[k] < m_tag[best]) ||
              (t_op[i] == 2 && m_tag[k] > m_tag[best])) begin
            best = k;
          end
        end
        p_tag = m_tag[best];
        p_data = m_data[best];
        m_tag.delete(best);
        m_data.delete(best);
      end
      e_kind.push_back(0);
      e_tag.push_back(p_tag);
      e_data.push_back(p_data);
      e_empty.push_back(p_flag);
      e_count.push_back(m_tag.size());
    end
    if (p_tag != t_exp_tag[i] || p_data != t_exp_data[i] || p_flag != t_flag[i] ||
        m_tag.size() != t_count[i]) begin
      $display("data file row %0d of test %0d disagrees with the reference model", i, t_num[i]);
      errors++;
    end
  endtask

  // results and rejections in command order
  always @(posedge clk_in) begin
    if (!rst_in && (res_valid || enq_rejected)) begin
      checks++;
      if (e_kind.size() == 0) begin
        $display("a strobe arrived at %0d ns with no command outstanding", $time);
        errors++;
      end else begin
        if (e_kind[0] == 1) begin
          if (!enq_rejected || res_valid) begin
            $display("expected an enqueue rejection at %0d ns but got a result", $time);
            errors++;
          end
          if (count !== COUNT_W'(e_count[0])) begin
            report_mismatch("count", 32'(count), e_count[0]);
          end
        end else if (!res_valid) begin
          $display("expected a dequeue result at %0d ns but got a rejection", $time);
          errors++;
        end else begin
          if (res_empty !== e_empty[0][0]) begin
            report_mismatch("res_empty", 32'(res_empty), e_empty[0]);
          end
          if (e_empty[0] == 0 && res_tag !== TAG_W'(e_tag[0])) begin
            report_mismatch("res_tag", 32'(res_tag), e_tag[0]);
          end
          if (e_empty[0] == 0 && res_data !== DATA_W'(e_data[0])) begin
            report_mismatch("res_data", 32'(res_data), e_data[0]);
          end
          if (count !== COUNT_W'(e_count[0])) begin
            report_mismatch("count", 32'(count), e_count[0]);
          end
        end
        void'(e_kind.pop_front());
        void'(e_tag.pop_front());
        void'(e_data.pop_front());
        void'(e_empty.pop_front());
        void'(e_count.pop_front());
      end
    end
  end

  initial begin
    int test_err;
    rst_in = 1'b1;
    cmd_valid = 1'b0;
    cmd_op = OP_ENQ;
    cmd_tag = '0;
    cmd_data = '0;
    test_err = 0;
    load_testdata();
    repeat (2) @(posedge clk_in);
    @(negedge clk_in);
    rst_in = 1'b0;
    checks++;
    if (count !== '0) begin
      report_mismatch("count", 32'(count), 0);
    end
    if (busy !== 1'b0) begin
      report_mismatch("busy", 32'(busy), 0);
    end
    for (int i = 0; i < n_cmds; i++) begin
      if (i == 0 || t_num[i] != t_num[i-1]) begin
        test_err = errors;
      end
      cmd_valid = 1'b1;
      cmd_op = op_e'(t_op[i][1:0]);
      cmd_tag = t_tag[i][TAG_W-1:0];
      cmd_data = t_data[i][DATA_W-1:0];
      apply_model(i);
      @(posedge clk_in);
      checks++;
      if (cmd_drop !== (t_flag[i] == 2)) begin
        report_mismatch("cmd_drop", 32'(cmd_drop), 32'(t_flag[i] == 2));
      end
      @(negedge clk_in);
      cmd_valid = 1'b0;
      // a command was just queued or met a full queue
      checks++;
      if (busy !== 1'b1) begin
        report_mismatch("busy", 32'(busy), 1);
      end
      repeat (t_gap[i]) @(negedge clk_in);
      if (i == n_cmds - 1 || t_num[i+1] != t_num[i]) begin
        // drain the test before the next one starts
        while (busy || e_kind.size() != 0) begin
          @(negedge clk_in);
        end
        checks++;
        if (count !== COUNT_W'(m_tag.size())) begin
          report_mismatch("count", 32'(count), m_tag.size());
        end
        $display("test %0d finished with %0d errors", t_num[i], errors - test_err);
      end
    end
    $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
             pq_top_inst.pq_sva_inst.fail_count);
    if (errors == 0 && n_cmds > 0 && pq_top_inst.pq_sva_inst.fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // limit grows with each command's gap and a full sweep
  initial begin
    int limit;
    wait (n_cmds > 0);
    limit = 100;
    for (int i = 0; i < n_cmds; i++) begin
      limit += t_gap[i] + 1 + DEPTH + 8;
    end
    #(limit * 2 * CLK_HALF);
    $display("timeout: the commands did not finish within %0d cycles", limit);
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* verification/pq_testdata.txt */
# test op(0 enq, 1 deq_min, 2 deq_max) tag data exp_tag exp_data flag count gap
# flag 1 = empty or rejected, 2 = dropped; tag and data in hex, the rest decimal
1 1 0000 0000 0000 0000 1 0 16
2 0 0500 a001 0000 0000 0 1 3
2 0 0120 a002 0000 0000 0 2 3
2 0 0a00 a003 0000 0000 0 3 3
2 0 0333 a004 0000 0000 0 4 3
2 0 0050 a005 0000 0000 0 5 3
2 0 0f00 a006 0000 0000 0 6 3
2 0 0777 a007 0000 0000 0 7 3
2 0 0200 a008 0000 0000 0 8 3
3 0 0010 a009 0000 0000 1 8 3
3 1 0000 0000 0050 a005 0 7 16
3 2 0000 0000 0f00 a006 0 6 16
3 1 0000 0000 0120 a002 0 5 16
3 2 0000 0000 0a00 a003 0 4 16
4 0 0400 b001 0000 0000 0 5 3
4 1 0000 0000 0200 a008 0 4 16
4 0 0900 b002 0000 0000 0 5 3
4 2 0000 0000 0900 b002 0 4 16
4 0 0030 b003 0000 0000 0 5 3
4 1 0000 0000 0030 b003 0 4 16
5 2 0000 0000 0777 a007 0 3 1
5 0 0600 c001 0000 0000 0 4 0
5 0 0100 c002 0000 0000 0 5 0
5 1 0000 0000 0100 c002 0 4 0
5 2 0000 0000 0600 c001 0 3 0
5 0 0800 c005 0000 0000 2 3 0
6 1 0000 0000 0333 a004 0 2 16
6 2 0000 0000 0500 a001 0 1 16
6 1 0000 0000 0400 b001 0 0 16
6 2 0000 0000 0000 0000 1 0 16
